/* src/axi_read_pkg.sv */
package axi_read_pkg;

	localparam int unsigned ADDR_WIDTH = 32;
	localparam int unsigned DATA_WIDTH = 64;
	localparam int unsigned LEN_WIDTH = 8;
	localparam int unsigned SIZE_WIDTH = 2;
	localparam int unsigned RESP_WIDTH = 2;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [LEN_WIDTH-1:0] len_t; // Beats minus one
	typedef logic [SIZE_WIDTH-1:0] size_t; // Log2 of bytes per beat
	typedef logic [RESP_WIDTH-1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// Address read request, every burst is INCR
	typedef struct packed {
		addr_t addr;
		len_t len;
		size_t size;
	} ar_req_t;

	// Read data beat, it carries its own address
	typedef struct packed {
		data_t data;
		addr_t addr;
		resp_t resp;
		logic last;
	} r_beat_t;

endpackage

/* src/core_read_pkg.sv */
package core_read_pkg;

	localparam int unsigned NUM_CLIENTS = 2; // Fetch and memory
	localparam int unsigned DISPATCH_DEPTH = 4;
	localparam int unsigned DISPATCH_PTR_W = $clog2(DISPATCH_DEPTH);
	localparam int unsigned RESULT_DEPTH = 2;

	typedef logic [$clog2(NUM_CLIENTS)-1:0] client_id_t;

	typedef struct packed {
		client_id_t id;
		axi_read_pkg::ar_req_t req;
	} read_cmd_t;

	typedef struct packed {
		client_id_t id;
		axi_read_pkg::r_beat_t beat;
	} read_res_t;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} client_state_t;

	// First requester at or after start, counting round the ring
	function automatic client_id_t rr_pick(input logic [NUM_CLIENTS-1:0] valid,
			input client_id_t start);
		int unsigned idx;
		client_id_t pick;
		pick = client_id_t'(int'(start) % NUM_CLIENTS);
		for (int k = NUM_CLIENTS - 1; k >= 0; k--) begin
			idx = (int'(start) + k) % NUM_CLIENTS;
			if (valid[idx])
				pick = client_id_t'(idx);
		end
		return pick;
	endfunction

endpackage

/* src/read_dispatch.sv */
`timescale 1ns/10ps

module read_dispatch (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	output logic cmd_ready,
	input  core_read_pkg::read_cmd_t cmd,
	output logic [core_read_pkg::NUM_CLIENTS-1:0] client_cmd_valid,
	output axi_read_pkg::ar_req_t client_cmd,
	input  logic [core_read_pkg::NUM_CLIENTS-1:0] client_cmd_ready
);

	core_read_pkg::read_cmd_t queue [core_read_pkg::DISPATCH_DEPTH];
	logic [core_read_pkg::DISPATCH_PTR_W-1:0] wr_ptr;
	logic [core_read_pkg::DISPATCH_PTR_W-1:0] rd_ptr;
	logic [core_read_pkg::DISPATCH_PTR_W:0] count;
	logic [core_read_pkg::DISPATCH_PTR_W:0] count_next;
	core_read_pkg::read_cmd_t head;
	logic push;
	logic pop;

	assign head = queue[rd_ptr];
	assign push = cmd_valid && cmd_ready;
	assign pop = (count != '0) && client_cmd_ready[head.id]; // Head leaves when its client takes it
	assign client_cmd = head.req;

	always_comb begin
		for (int i = 0; i < core_read_pkg::NUM_CLIENTS; i++)
			client_cmd_valid[i] = (count != '0) && (head.id == core_read_pkg::client_id_t'(i));
	end

	always_comb begin
		count_next = count;
		if (push && !pop)
			count_next = count + 1'b1;
		else if (pop && !push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cmd_ready <= 1'b0; // Rises on the first cycle out of reset
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			cmd_ready <= count_next < (core_read_pkg::DISPATCH_PTR_W + 1)'(core_read_pkg::DISPATCH_DEPTH);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			queue[wr_ptr] <= cmd;
	end

endmodule

/* src/read_client.sv */
`timescale 1ns/10ps

module read_client #(
	parameter core_read_pkg::client_id_t CLIENT_ID = '0
) (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	output logic cmd_ready,
	input  axi_read_pkg::ar_req_t cmd,
	output logic ar_valid,
	input  logic ar_ready,
	output axi_read_pkg::ar_req_t ar,
	input  logic r_valid,
	output logic r_ready,
	input  axi_read_pkg::r_beat_t r,
	output logic res_valid,
	input  logic res_ready,
	output axi_read_pkg::r_beat_t res
);

	core_read_pkg::client_state_t state;
	axi_read_pkg::ar_req_t req_q;
	axi_read_pkg::len_t beat_cnt;

	axi_read_pkg::r_beat_t buf_mem [core_read_pkg::RESULT_DEPTH];
	logic [$clog2(core_read_pkg::RESULT_DEPTH)-1:0] wr_ptr;
	logic [$clog2(core_read_pkg::RESULT_DEPTH)-1:0] rd_ptr;
	logic [$clog2(core_read_pkg::RESULT_DEPTH):0] fill;
	logic push;
	logic pop;

	assign cmd_ready = (state == core_read_pkg::IDLE);
	assign ar_valid = (state == core_read_pkg::ADDR);
	assign ar = req_q;

	// Bus side stalls once both result slots are taken
	assign r_ready = (state == core_read_pkg::DATA) && (fill < core_read_pkg::RESULT_DEPTH);
	assign push = r_valid && r_ready;

	assign res_valid = (fill != '0);
	assign res = buf_mem[rd_ptr];
	assign pop = res_valid && res_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= core_read_pkg::IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				core_read_pkg::IDLE: begin
					if (cmd_valid)
						state <= core_read_pkg::ADDR;
				end
				core_read_pkg::ADDR: begin
					if (ar_ready) begin
						state <= core_read_pkg::DATA;
						beat_cnt <= '0;
					end
				end
				core_read_pkg::DATA: begin
					if (push) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (r.last || beat_cnt == req_q.len)
							state <= core_read_pkg::IDLE; // Burst done
					end
				end
				default: state <= core_read_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_read_pkg::IDLE && cmd_valid)
			req_q <= cmd;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= CLIENT_ID; // Each client starts in its own slot
			rd_ptr <= CLIENT_ID;
			fill <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				fill <= fill + 1'b1;
			else if (pop && !push)
				fill <= fill - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			buf_mem[wr_ptr] <= r;
	end

endmodule

/* src/axi_read_arbiter.sv */
`timescale 1ns/10ps

module axi_read_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic [core_read_pkg::NUM_CLIENTS-1:0] req_valid,
	output logic [core_read_pkg::NUM_CLIENTS-1:0] req_ready,
	input  axi_read_pkg::ar_req_t req [core_read_pkg::NUM_CLIENTS],
	output logic m_ar_valid,
	input  logic m_ar_ready,
	output axi_read_pkg::ar_req_t m_ar,
	input  logic m_r_valid,
	output logic m_r_ready,
	input  axi_read_pkg::r_beat_t m_r,
	output logic [core_read_pkg::NUM_CLIENTS-1:0] beat_valid,
	input  logic [core_read_pkg::NUM_CLIENTS-1:0] beat_ready,
	output axi_read_pkg::r_beat_t beat
);

	logic busy; // Bus locked to owner until its last beat
	logic ar_sent;
	core_read_pkg::client_id_t owner;
	core_read_pkg::client_id_t rr_ptr;
	core_read_pkg::client_id_t pick;
	logic last_accept;

	assign pick = core_read_pkg::rr_pick(req_valid, rr_ptr);
	assign last_accept = m_r_valid && m_r_ready && m_r.last;

	assign m_ar_valid = busy && !ar_sent && req_valid[owner];
	assign m_ar = req[owner];
	assign m_r_ready = busy && ar_sent && beat_ready[owner];
	assign beat = m_r; // Only the owner sees valid

	always_comb begin
		for (int i = 0; i < core_read_pkg::NUM_CLIENTS; i++) begin
			req_ready[i] = busy && !ar_sent && m_ar_ready
				&& (owner == core_read_pkg::client_id_t'(i));
			beat_valid[i] = busy && ar_sent && m_r_valid
				&& (owner == core_read_pkg::client_id_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			ar_sent <= 1'b0;
			owner <= '0;
			rr_ptr <= '0;
		end else if (!busy) begin
			if (|req_valid) begin
				busy <= 1'b1;
				ar_sent <= 1'b0;
				owner <= pick;
			end
		end else begin
			if (m_ar_valid && m_ar_ready)
				ar_sent <= 1'b1;
			if (last_accept) begin
				busy <= 1'b0;
				ar_sent <= 1'b0;
				rr_ptr <= owner + 1'b1; // Next search starts past the owner
			end
		end
	end

endmodule

/* src/result_collect.sv */
`timescale 1ns/10ps

module result_collect (
	input  logic clk,
	input  logic reset,
	input  logic [core_read_pkg::NUM_CLIENTS-1:0] in_valid,
	output logic [core_read_pkg::NUM_CLIENTS-1:0] in_ready,
	input  axi_read_pkg::r_beat_t in_beat [core_read_pkg::NUM_CLIENTS],
	output logic res_valid,
	input  logic res_ready,
	output core_read_pkg::read_res_t res
);

	logic locked;
	core_read_pkg::client_id_t owner;
	core_read_pkg::client_id_t rr_ptr;
	core_read_pkg::client_id_t sel;
	logic out_free;
	logic accept;

	// A burst in progress keeps its source selected
	assign sel = locked ? owner : core_read_pkg::rr_pick(in_valid, rr_ptr);
	assign out_free = !res_valid || res_ready;
	assign accept = in_valid[sel] && out_free;

	always_comb begin
		for (int i = 0; i < core_read_pkg::NUM_CLIENTS; i++)
			in_ready[i] = out_free && (sel == core_read_pkg::client_id_t'(i));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			locked <= 1'b0;
			owner <= '0;
			rr_ptr <= '0;
		end else if (accept) begin
			res_valid <= 1'b1;
			if (in_beat[sel].last) begin
				locked <= 1'b0;
				rr_ptr <= sel + 1'b1;
			end else begin
				locked <= 1'b1;
				owner <= sel;
			end
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			res.id <= sel; // Tag with the source index
			res.beat <= in_beat[sel];
		end
	end

endmodule

/* src/read_subsystem_top.sv */
`timescale 1ns/10ps

module read_subsystem_top (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	output logic cmd_ready,
	input  core_read_pkg::read_cmd_t cmd,
	output logic res_valid,
	input  logic res_ready,
	output core_read_pkg::read_res_t res,
	output logic m_ar_valid,
	input  logic m_ar_ready,
	output axi_read_pkg::ar_req_t m_ar,
	input  logic m_r_valid,
	output logic m_r_ready,
	input  axi_read_pkg::r_beat_t m_r
);

	logic [core_read_pkg::NUM_CLIENTS-1:0] client_cmd_valid;
	logic [core_read_pkg::NUM_CLIENTS-1:0] client_cmd_ready;
	axi_read_pkg::ar_req_t client_cmd;

	logic [core_read_pkg::NUM_CLIENTS-1:0] ar_valid;
	logic [core_read_pkg::NUM_CLIENTS-1:0] ar_ready;
	axi_read_pkg::ar_req_t ar [core_read_pkg::NUM_CLIENTS];

	logic [core_read_pkg::NUM_CLIENTS-1:0] r_valid;
	logic [core_read_pkg::NUM_CLIENTS-1:0] r_ready;
	axi_read_pkg::r_beat_t r_beat;

	logic [core_read_pkg::NUM_CLIENTS-1:0] client_res_valid;
	logic [core_read_pkg::NUM_CLIENTS-1:0] client_res_ready;
	axi_read_pkg::r_beat_t client_res [core_read_pkg::NUM_CLIENTS];

	read_dispatch u_dispatch (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.client_cmd_valid(client_cmd_valid),
		.client_cmd(client_cmd),
		.client_cmd_ready(client_cmd_ready)
	);

	for (genvar i = 0; i < core_read_pkg::NUM_CLIENTS; i++) begin : g_client
		read_client #(
			.CLIENT_ID(core_read_pkg::client_id_t'(i))
		) u_client (
			.clk(clk),
			.reset(reset),
			.cmd_valid(client_cmd_valid[i]),
			.cmd_ready(client_cmd_ready[i]),
			.cmd(client_cmd),
			.ar_valid(ar_valid[i]),
			.ar_ready(ar_ready[i]),
			.ar(ar[i]),
			.r_valid(r_valid[i]),
			.r_ready(r_ready[i]),
			.r(r_beat),
			.res_valid(client_res_valid[i]),
			.res_ready(client_res_ready[i]),
			.res(client_res[i])
		);
	end

	axi_read_arbiter u_arbiter (
		.clk(clk),
		.reset(reset),
		.req_valid(ar_valid),
		.req_ready(ar_ready),
		.req(ar),
		.m_ar_valid(m_ar_valid),
		.m_ar_ready(m_ar_ready),
		.m_ar(m_ar),
		.m_r_valid(m_r_valid),
		.m_r_ready(m_r_ready),
		.m_r(m_r),
		.beat_valid(r_valid),
		.beat_ready(r_ready),
		.beat(r_beat)
	);

	result_collect u_collect (
		.clk(clk),
		.reset(reset),
		.in_valid(client_res_valid),
		.in_ready(client_res_ready),
		.in_beat(client_res),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res(res)
	);

endmodule

/* tests/axi_slave_model.sv */
`timescale 1ns/10ps

module axi_slave_model (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] rnd,
	input  logic m_ar_valid,
	output logic m_ar_ready,
	input  axi_read_pkg::ar_req_t m_ar,
	output logic m_r_valid,
	input  logic m_r_ready,
	output axi_read_pkg::r_beat_t m_r
);

	axi_read_pkg::ar_req_t burst;
	axi_read_pkg::len_t beat_idx;
	logic in_burst;
	logic [1:0] ar_delay;

	// Beat k of an INCR burst, data is a scrambled copy of its address
	function automatic axi_read_pkg::r_beat_t beat_at(input axi_read_pkg::ar_req_t a,
			input axi_read_pkg::len_t k);
		axi_read_pkg::r_beat_t b;
		b.addr = a.addr + (axi_read_pkg::addr_t'(k) << a.size);
		b.data = {32'h0, b.addr} ^ 64'h5a5a_c3c3_0f0f_a5a5;
		b.resp = b.addr[31] ? axi_read_pkg::RESP_SLVERR : axi_read_pkg::RESP_OKAY;
		b.last = (k == a.len);
		return b;
	endfunction

	initial begin
		m_ar_ready = 1'b0;
		m_r_valid = 1'b0;
		m_r = '0;
	end

	always @(posedge clk) begin
		if (reset) begin
			m_ar_ready <= 1'b0;
			m_r_valid <= 1'b0;
			in_burst <= 1'b0;
			ar_delay <= 2'd1;
			beat_idx <= '0;
		end else if (!in_burst) begin
			if (m_ar_valid && m_ar_ready) begin
				burst <= m_ar;
				beat_idx <= '0;
				in_burst <= 1'b1;
				m_ar_ready <= 1'b0;
				ar_delay <= rnd[1:0]; // Wait before the next AR
			end else if (m_ar_valid) begin
				if (ar_delay == 2'd0)
					m_ar_ready <= 1'b1;
				else
					ar_delay <= ar_delay - 1'b1;
			end
		end else if (m_r_valid && m_r_ready) begin
			if (m_r.last) begin
				m_r_valid <= 1'b0;
				in_burst <= 1'b0;
			end else begin
				beat_idx <= beat_idx + 1'b1;
				m_r_valid <= (rnd[3:2] != 2'd0);
				m_r <= beat_at(burst, beat_idx + 1'b1);
			end
		end else if (!m_r_valid && rnd[3:2] != 2'd0) begin
			m_r_valid <= 1'b1; // Random gap ends here
			m_r <= beat_at(burst, beat_idx);
		end
	end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	input  logic cmd_ready,
	input  core_read_pkg::read_cmd_t cmd,
	input  logic res_valid,
	input  logic res_ready,
	input  core_read_pkg::read_res_t res,
	input  logic m_ar_valid,
	input  logic m_ar_ready,
	input  logic m_r_valid,
	input  logic m_r_ready,
	input  axi_read_pkg::r_beat_t m_r,
	output int error_count,
	output int pending,
	output int beats_checked
);

	axi_read_pkg::r_beat_t exp_q [core_read_pkg::NUM_CLIENTS][$];
	int errs = 0;
	int outstanding = 0;
	int checked = 0;
	logic burst_open = 1'b0;
	logic reset_q = 1'b0;
	logic stall_q = 1'b0;
	core_read_pkg::read_res_t res_hold;

	initial begin
		error_count = 0;
		pending = 0;
		beats_checked = 0;
	end

	// Expected beat k of a command, worked out from the slave's address and data rule
	function automatic axi_read_pkg::r_beat_t expected_beat(input axi_read_pkg::ar_req_t req,
			input int k);
		axi_read_pkg::r_beat_t b;
		b.addr = req.addr + (axi_read_pkg::addr_t'(k) << req.size);
		b.data = {32'h0, b.addr} ^ 64'h5a5a_c3c3_0f0f_a5a5;
		b.resp = b.addr[31] ? axi_read_pkg::RESP_SLVERR : axi_read_pkg::RESP_OKAY;
		b.last = (k == int'(req.len));
		return b;
	endfunction

	task automatic value_error(input string field, input int id, input logic [63:0] got,
			input logic [63:0] want);
		errs++;
		$display("ERR %0t: client %0d %s is %h, expected %h", $time, id, field, got, want);
	endtask

	task automatic fault(input string what);
		errs++;
		$display("Check failed at %0t: %s", $time, what);
	endtask

	always @(posedge clk) begin
		axi_read_pkg::r_beat_t want;
		if (reset_q && (m_ar_valid || res_valid || cmd_ready))
			fault("outputs were not idle right after reset");
		if (stall_q && (!res_valid || res !== res_hold))
			fault("res changed while res_valid was high and res_ready was low");
		if (!reset && cmd_valid && cmd_ready) begin
			for (int k = 0; k <= int'(cmd.req.len); k++)
				exp_q[cmd.id].push_back(expected_beat(cmd.req, k));
			outstanding += int'(cmd.req.len) + 1;
		end
		if (!reset && res_valid && res_ready) begin
			if (exp_q[res.id].size() == 0) begin
				fault($sformatf("a result for client %0d arrived with none expected", res.id));
			end else begin
				want = exp_q[res.id].pop_front();
				outstanding--;
				checked++;
				if (res.beat.addr !== want.addr)
					value_error("addr", res.id, 64'(res.beat.addr), 64'(want.addr));
				if (res.beat.data !== want.data)
					value_error("data", res.id, res.beat.data, want.data);
				if (res.beat.resp !== want.resp)
					value_error("resp", res.id, 64'(res.beat.resp), 64'(want.resp));
				if (res.beat.last !== want.last)
					value_error("last", res.id, 64'(res.beat.last), 64'(want.last));
			end
		end
		// Only one burst may be open on the bus
		if (!reset && m_ar_valid && m_ar_ready) begin
			if (burst_open)
				fault("an AR transfer happened before the open burst saw its last beat");
			burst_open = 1'b1;
		end
		if (!reset && m_r_valid && m_r_ready && m_r.last)
			burst_open = 1'b0;
		reset_q <= reset;
		stall_q <= !reset && res_valid && !res_ready;
		res_hold <= res;
		error_count <= errs;
		pending <= outstanding;
		beats_checked <= checked;
	end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

	localparam int NUM_TESTS = 6;
	localparam logic [31:0] SEED = 32'hd74afb3e;

	logic clk = 1'b0;
	logic reset;
	logic cmd_valid;
	logic cmd_ready;
	core_read_pkg::read_cmd_t cmd;
	logic res_valid;
	logic res_ready;
	core_read_pkg::read_res_t res;
	logic m_ar_valid;
	logic m_ar_ready;
	axi_read_pkg::ar_req_t m_ar;
	logic m_r_valid;
	logic m_r_ready;
	axi_read_pkg::r_beat_t m_r;

	logic [31:0] gen_state;
	logic [31:0] rnd;
	logic rr_random = 1'b0; // Random res_ready with long stalls
	int stall_cnt;
	int chk_errors;
	int chk_pending;
	int chk_checked;
	int cycle_count = 0;
	int timeout_limit = 200;
	int total_beats = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	core_read_pkg::read_cmd_t cmd_list[$];
	int cmd_test[$];
	string test_name [NUM_TESTS] = '{"reset", "single beats", "bursts", "slave error",
		"random", "backpressure"};

	always #4 clk = ~clk;

	read_subsystem_top dut (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res(res),
		.m_ar_valid(m_ar_valid),
		.m_ar_ready(m_ar_ready),
		.m_ar(m_ar),
		.m_r_valid(m_r_valid),
		.m_r_ready(m_r_ready),
		.m_r(m_r)
	);

	axi_slave_model slave (.*);

	tb_checker chk (
		.*,
		.error_count(chk_errors),
		.pending(chk_pending),
		.beats_checked(chk_checked)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		gen_state = xorshift(gen_state);
		return gen_state;
	endfunction

	function automatic void add_cmd(input int test, input int id, input logic [31:0] addr,
			input int len, input int size);
		core_read_pkg::read_cmd_t c;
		c.id = core_read_pkg::client_id_t'(id);
		c.req.addr = addr;
		c.req.len = axi_read_pkg::len_t'(len);
		c.req.size = axi_read_pkg::size_t'(size);
		cmd_list.push_back(c);
		cmd_test.push_back(test);
		total_beats += len + 1;
	endfunction

	function automatic void build_tests();
		logic [31:0] r;
		add_cmd(0, 0, 32'h0000_1000, 0, 3);
		add_cmd(1, 0, rand_word() & 32'h7fff_fff8, 0, 3);
		add_cmd(1, 1, rand_word() & 32'h7fff_fffc, 0, 2);
		for (int size = 0; size < 4; size++)
			for (int len = 1; len < 8; len++)
				add_cmd(2, (len + size) % 2, rand_word() & 32'h7fff_fff0, len, size);
		for (int i = 0; i < 4; i++)
			add_cmd(3, i % 2, (rand_word() & 32'h7fff_fff0)
				| ((i % 3 == 0) ? 32'h8000_0000 : 32'h0), 3, 3);
		for (int i = 0; i < 70; i++) begin
			r = rand_word();
			add_cmd(i < 40 ? 4 : 5, r[0], rand_word(), r[3:1], r[5:4]);
		end
	endfunction

	// Per-cycle random word, also shapes res_ready
	always @(posedge clk) begin
		if (reset) begin
			rnd <= gen_state;
			res_ready <= 1'b0;
			stall_cnt <= 0;
		end else begin
			rnd <= xorshift(rnd);
			if (!rr_random) begin
				res_ready <= 1'b1;
			end else if (stall_cnt != 0) begin
				stall_cnt <= stall_cnt - 1;
				res_ready <= 1'b0;
			end else if (rnd[15:12] == 4'h0) begin
				stall_cnt <= 24 + int'(rnd[20:16]); // Long run with res_ready low
				res_ready <= 1'b0;
			end else begin
				res_ready <= rnd[8];
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timed out after %0d cycles with %0d beats still missing",
				cycle_count, chk_pending);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic send_cmd(input core_read_pkg::read_cmd_t c);
		cmd_valid <= 1'b1;
		cmd <= c;
		@(posedge clk);
		while (!cmd_ready)
			@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		do
			@(posedge clk);
		while (chk_pending != 0);
	endtask

	task automatic run_test(input int t);
		int errs_before;
		int sent;
		errs_before = chk_errors;
		sent = 0;
		rr_random <= (t == 5);
		for (int i = 0; i < cmd_list.size(); i++) begin
			if (cmd_test[i] == t) begin
				send_cmd(cmd_list[i]);
				sent++;
			end
		end
		wait_drain();
		if (chk_errors != errs_before)
			tests_failed++;
		else
			tests_passed++;
		$display("test %0d %s: %0d commands, %0d errors", t, test_name[t], sent,
			chk_errors - errs_before);
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		res_ready = 1'b0;
		gen_state = SEED;
		build_tests();
		timeout_limit = 40 * total_beats + 200;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("tests passed %0d, tests failed %0d, beats checked %0d", tests_passed,
			tests_failed, chk_checked);
		if (tests_failed == 0 && chk_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* flist.f */
src/axi_read_pkg.sv
src/core_read_pkg.sv
src/read_dispatch.sv
src/read_client.sv
src/axi_read_arbiter.sv
src/result_collect.sv
src/read_subsystem_top.sv
tests/axi_slave_model.sv
tests/tb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: axi_read_subsystem

sources:
  - src/axi_read_pkg.sv
  - src/core_read_pkg.sv
  - src/read_dispatch.sv
  - src/read_client.sv
  - src/axi_read_arbiter.sv
  - src/result_collect.sv
  - src/read_subsystem_top.sv
  - target: test
    files:
      - tests/axi_slave_model.sv
      - tests/tb_checker.sv
      - tests/tb_top.sv
